//--- design/zx_pkg.sv
// Spectrum paging core shared definitions
// Machine model codes, address types and the bus and register state structs
package zx_pkg;

	// ==================================================
	// Machine models
	// ==================================================
	typedef logic [2:0] zx_model_t;

	localparam zx_model_t MODEL_ZX128 = 3'd0;
	localparam zx_model_t MODEL_P1024 = 3'd1;
	localparam zx_model_t MODEL_ZX48  = 3'd3;
	localparam zx_model_t MODEL_PLUS3 = 3'd4;

	// ==================================================
	// Addresses
	// ==================================================
	typedef logic [15:0] cpu_addr_t;
	typedef logic [24:0] phys_addr_t;

	// Offset width inside one 16 KB bank
	localparam int BANK_BITS = 14;

	// ==================================================
	// Bus and state structs
	// ==================================================
	// One CPU cycle as seen on the slave port
	typedef struct packed {
		logic       io;
		logic       we;
		cpu_addr_t  adr;
		logic [7:0] dat;
	} cpu_req_t;

	// Paging registers plus the latched model
	typedef struct packed {
		logic [7:0] reg_7ffd;
		logic [7:0] reg_1ffd;
		logic [7:0] reg_eff7;
		logic [2:0] bank_hi;
		zx_model_t  model;
	} page_state_t;

	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
		logic       screen_page;
	} ula_state_t;

endpackage

//--- design/zx_io_ports.sv
`timescale 1ns/10ps
// Spectrum I/O port decode
// Holds the paging registers 7FFD, 1FFD, EFF7 and the ULA port FE
module zx_io_ports (
	input  logic                clk_sys,
	input  logic                reset,
	input  zx_pkg::zx_model_t   model,
	input  logic                io_wr,
	input  zx_pkg::cpu_addr_t   adr,
	input  logic [7:0]          dat,
	output zx_pkg::page_state_t page,
	output zx_pkg::ula_state_t  ula
);
	import zx_pkg::*;

	zx_model_t  model_q;
	logic [7:0] reg_7ffd;
	logic [7:0] reg_1ffd;
	logic [7:0] reg_eff7;
	logic [2:0] bank_hi;
	logic [2:0] border;
	logic       ear;
	logic       mic;

	logic is_zx48;
	logic is_p1024;
	logic is_plus3;
	logic p1024_ext;
	logic page_disable;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_eff7;
	logic sel_ula;

	assign is_zx48  = (model_q == MODEL_ZX48);
	assign is_p1024 = (model_q == MODEL_P1024);
	assign is_plus3 = (model_q == MODEL_PLUS3);

	// Pentagon 1024 extended banking, off once EFF7 bit 2 is set
	assign p1024_ext = is_p1024 & ~reg_eff7[2];

	// 48K lock from 7FFD bit 5 does not apply in extended mode
	assign page_disable = is_zx48 | (reg_7ffd[5] & ~p1024_ext);

	// ==================================================
	// Port decode
	// ==================================================
	assign sel_1ffd = is_plus3 & adr[12] & ~adr[15] & ~adr[14] & ~adr[13] & ~adr[1];
	assign sel_7ffd = ~adr[15] & ~adr[1] & (adr[14] | is_plus3) & ~sel_1ffd;
	assign sel_eff7 = is_p1024 & (&adr[15:13]) & ~adr[12] & ~adr[3];
	assign sel_ula  = ~adr[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			reg_7ffd <= '0;
			reg_1ffd <= '0;
			reg_eff7 <= '0;
			bank_hi  <= '0;
			border   <= '0;
			ear      <= 1'b0;
			mic      <= 1'b0;
			// Unknown codes fall back to 128
			case (model)
				MODEL_P1024, MODEL_ZX48, MODEL_PLUS3: begin
					model_q <= model;
				end
				default: begin
					model_q <= MODEL_ZX128;
				end
			endcase
		end else if (io_wr) begin
			if (sel_1ffd && !page_disable) begin
				reg_1ffd <= dat;
			end else if (sel_7ffd && !page_disable) begin
				reg_7ffd <= dat;
				// Extra bank bits come from D5, D7, D6
				if (p1024_ext) begin
					bank_hi <= {dat[5], dat[7], dat[6]};
				end
			end
			if (sel_eff7) begin
				reg_eff7 <= dat;
			end
			if (sel_ula) begin
				border <= dat[2:0];
				mic    <= dat[3];
				ear    <= dat[4];
			end
		end
	end

	assign page = '{reg_7ffd: reg_7ffd, reg_1ffd: reg_1ffd, reg_eff7: reg_eff7,
			bank_hi: bank_hi, model: model_q};

	assign ula = '{border: border, ear: ear, mic: mic, screen_page: reg_7ffd[3]};

	// Strobe from the bridge must be clean once out of reset
	a_io_wr_known: assert property (@(posedge clk_sys) disable iff (reset)
			!$isunknown(io_wr))
		else $error("io_wr is unknown");

endmodule

//--- design/zx_mem_map.sv
`timescale 1ns/10ps
// Spectrum memory map
// Turns a CPU address into a physical ROM or RAM address and flags writable areas
module zx_mem_map #(
	parameter zx_pkg::phys_addr_t ROM_BASE = 25'h140000,
	parameter zx_pkg::phys_addr_t RAM_BASE = 25'h0
) (
	input  zx_pkg::page_state_t page,
	input  zx_pkg::cpu_addr_t   adr,
	output zx_pkg::phys_addr_t  phys_adr,
	output logic                wr_allowed
);
	import zx_pkg::*;

	logic       special;
	logic [1:0] special_mode;
	logic [1:0] quarter;
	logic [1:0] rom_page;
	logic [5:0] bank;
	logic       is_rom;
	phys_addr_t rom_off;
	phys_addr_t ram_off;

	// +3 all-RAM modes
	assign special      = page.reg_1ffd[0];
	assign special_mode = page.reg_1ffd[2:1];
	assign quarter      = adr[15:14];

	always_comb begin
		if (page.model == MODEL_PLUS3) begin
			rom_page = {page.reg_1ffd[2], page.reg_7ffd[4]};
		end else if (page.model == MODEL_ZX48) begin
			rom_page = 2'd3;
		end else begin
			rom_page = {1'b0, page.reg_7ffd[4]};
		end
	end

	always_comb begin
		is_rom = 1'b0;
		bank   = 6'd0;
		if (special) begin
			// Quarter banks 0123, 4567, 4563, 4763
			case (quarter)
				2'd0: bank = (special_mode == 2'd0) ? 6'd0 : 6'd4;
				2'd1: bank = (special_mode == 2'd0) ? 6'd1 :
						(special_mode == 2'd3) ? 6'd7 : 6'd5;
				2'd2: bank = (special_mode == 2'd0) ? 6'd2 : 6'd6;
				default: bank = (special_mode == 2'd1) ? 6'd7 : 6'd3;
			endcase
		end else begin
			case (quarter)
				2'd0: is_rom = 1'b1;
				2'd1: bank = 6'd5;
				2'd2: bank = 6'd2;
				default: bank = {page.bank_hi, page.reg_7ffd[2:0]};
			endcase
		end
	end

	assign rom_off = phys_addr_t'({rom_page, adr[BANK_BITS-1:0]});
	assign ram_off = phys_addr_t'({bank, adr[BANK_BITS-1:0]});

	assign phys_adr   = is_rom ? (ROM_BASE + rom_off) : (RAM_BASE + ram_off);
	assign wr_allowed = special | (quarter != 2'd0);

endmodule

//--- design/zx_bus_bridge.sv
`timescale 1ns/10ps
// CPU bus bridge
// Answers Wishbone slave cycles directly or through a Wishbone master memory cycle
module zx_bus_bridge (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               cpu_cyc,
	input  logic               cpu_stb,
	input  zx_pkg::cpu_req_t   cpu_req,
	input  zx_pkg::phys_addr_t phys_adr,
	input  logic               wr_allowed,
	input  logic [7:0]         mem_rdat,
	input  logic               mem_ack,
	output logic               cpu_ack,
	output logic [7:0]         cpu_rdat,
	output logic               mem_cyc,
	output logic               mem_stb,
	output logic               mem_we,
	output zx_pkg::phys_addr_t mem_adr,
	output logic [7:0]         mem_wdat,
	output logic               io_wr
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MEM_WAIT,
		ST_ACK
	} state_t;

	state_t state;
	logic   start;
	logic   drop_wr;

	// New CPU cycle seen while idle
	assign start   = (state == ST_IDLE) && cpu_cyc && cpu_stb;
	assign io_wr   = start && cpu_req.io && cpu_req.we;
	assign drop_wr = !cpu_req.io && cpu_req.we && !wr_allowed;

	// ==================================================
	// Sequencer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= ST_IDLE;
			cpu_ack <= 1'b0;
			mem_cyc <= 1'b0;
			mem_stb <= 1'b0;
		end else begin
			cpu_ack <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						if (cpu_req.io || drop_wr) begin
							cpu_ack <= 1'b1;
							state   <= ST_ACK;
						end else begin
							mem_cyc <= 1'b1;
							mem_stb <= 1'b1;
							state   <= ST_MEM_WAIT;
						end
					end
				end
				ST_MEM_WAIT: begin
					// Wait states end with mem_ack
					if (mem_ack) begin
						mem_cyc <= 1'b0;
						mem_stb <= 1'b0;
						cpu_ack <= 1'b1;
						state   <= ST_ACK;
					end
				end
				ST_ACK: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Master address and data, read data back to the CPU
	always_ff @(posedge clk_sys) begin
		if (start) begin
			mem_adr  <= phys_adr;
			mem_we   <= cpu_req.we;
			mem_wdat <= cpu_req.dat;
			cpu_rdat <= 8'hFF;
		end
		if (state == ST_MEM_WAIT && mem_ack) begin
			cpu_rdat <= mem_rdat;
		end
	end

	a_stb_in_cyc: assert property (@(posedge clk_sys) disable iff (reset)
			mem_stb |-> mem_cyc)
		else $error("mem_stb high outside mem_cyc");

	a_ack_pulse: assert property (@(posedge clk_sys) disable iff (reset)
			cpu_ack |=> !cpu_ack)
		else $error("cpu_ack held for two cycles");

endmodule

//--- design/zx_mapper_top.sv
`timescale 1ns/10ps
// Spectrum memory paging and ULA port core
// Connects port registers, memory map and the Wishbone bridge
module zx_mapper_top #(
	parameter zx_pkg::phys_addr_t ROM_BASE = 25'h140000,
	parameter zx_pkg::phys_addr_t RAM_BASE = 25'h0
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_pkg::zx_model_t  model,
	input  logic               cpu_cyc,
	input  logic               cpu_stb,
	input  zx_pkg::cpu_req_t   cpu_req,
	output logic               cpu_ack,
	output logic [7:0]         cpu_rdat,
	output logic               mem_cyc,
	output logic               mem_stb,
	output logic               mem_we,
	output zx_pkg::phys_addr_t mem_adr,
	output logic [7:0]         mem_wdat,
	input  logic [7:0]         mem_rdat,
	input  logic               mem_ack,
	output zx_pkg::ula_state_t ula
);
	import zx_pkg::*;

	logic        io_wr;
	logic        wr_allowed;
	page_state_t page;
	phys_addr_t  phys_adr;

	zx_io_ports u_io_ports (
		.clk_sys (clk_sys),
		.reset   (reset),
		.model   (model),
		.io_wr   (io_wr),
		.adr     (cpu_req.adr),
		.dat     (cpu_req.dat),
		.page    (page),
		.ula     (ula)
	);

	zx_mem_map #(
		.ROM_BASE (ROM_BASE),
		.RAM_BASE (RAM_BASE)
	) u_mem_map (
		.page       (page),
		.adr        (cpu_req.adr),
		.phys_adr   (phys_adr),
		.wr_allowed (wr_allowed)
	);

	zx_bus_bridge u_bridge (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_cyc    (cpu_cyc),
		.cpu_stb    (cpu_stb),
		.cpu_req    (cpu_req),
		.phys_adr   (phys_adr),
		.wr_allowed (wr_allowed),
		.mem_rdat   (mem_rdat),
		.mem_ack    (mem_ack),
		.cpu_ack    (cpu_ack),
		.cpu_rdat   (cpu_rdat),
		.mem_cyc    (mem_cyc),
		.mem_stb    (mem_stb),
		.mem_we     (mem_we),
		.mem_adr    (mem_adr),
		.mem_wdat   (mem_wdat),
		.io_wr      (io_wr)
	);

endmodule

//--- bench/zx_mem_model.sv
`timescale 1ns/10ps
// Wishbone memory responder for the paging core testbench
// Random wait states, address-based fill pattern and a log of every write
module zx_mem_model (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               cyc,
	input  logic               stb,
	input  logic               we,
	input  zx_pkg::phys_addr_t adr,
	input  logic [7:0]         wdat,
	output logic [7:0]         rdat,
	output logic               ack
);
	import zx_pkg::*;

	phys_addr_t  log_adr[$];
	logic [7:0]  log_dat[$];
	phys_addr_t  last_adr;
	int          n_cycles;
	int          n_writes;
	logic        busy;
	logic [1:0]  wait_left;
	logic [31:0] rng;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Latest logged write wins, otherwise a pattern of the full address
	function automatic logic [7:0] content(input phys_addr_t a);
		logic [7:0] d;
		d = a[7:0] ^ a[15:8] ^ a[23:16] ^ {a[24], 7'h35};
		foreach (log_adr[i]) begin
			if (log_adr[i] == a) begin
				d = log_dat[i];
			end
		end
		return d;
	endfunction

	initial begin
		ack      = 1'b0;
		rdat     = 8'h00;
		busy     = 1'b0;
		n_cycles = 0;
		n_writes = 0;
		rng      = 32'ha93b_e7a8;
	end

	// ==================================================
	// Responder
	// ==================================================
	always @(posedge clk_sys) begin
		ack <= 1'b0;
		if (reset) begin
			busy <= 1'b0;
		end else if (cyc && stb && !ack) begin
			// First cycle draws 0 to 3 wait states
			if (!busy) begin
				rng <= xorshift(rng);
			end
			if (busy ? (wait_left == 2'd0) : (rng[1:0] == 2'd0)) begin
				ack      <= 1'b1;
				busy     <= 1'b0;
				last_adr <= adr;
				n_cycles <= n_cycles + 1;
				rdat     <= content(adr);
				if (we) begin
					log_adr.push_back(adr);
					log_dat.push_back(wdat);
					n_writes <= n_writes + 1;
				end
			end else if (busy) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				wait_left <= rng[1:0] - 2'd1;
				busy      <= 1'b1;
			end
		end
	end

endmodule

//--- bench/zx_mapper_tb.sv
`timescale 1ns/10ps
// Testbench for the Spectrum paging core
// Runs a table of CPU cycles and checks physical addresses, read data and ULA state
module zx_mapper_tb;
	import zx_pkg::*;

	localparam phys_addr_t ROM_BASE = 25'h140000;
	localparam phys_addr_t RAM_BASE = 25'h0;
	localparam int         TIMEOUT  = 200;

	localparam logic [1:0] K_RD  = 2'd0;
	localparam logic [1:0] K_WR  = 2'd1;
	localparam logic [1:0] K_IOW = 2'd2;
	localparam logic [1:0] K_IOR = 2'd3;

	// Expected value is a physical address, or the ula value for I/O rows
	typedef struct packed {
		zx_model_t  model;
		logic [1:0] kind;
		cpu_addr_t  adr;
		logic [7:0] dat;
		phys_addr_t exp_val;
		logic       no_mem;
	} row_t;

	logic       clk_sys;
	logic       reset;
	zx_model_t  model;
	logic       cpu_cyc;
	logic       cpu_stb;
	cpu_req_t   cpu_req;
	logic       cpu_ack;
	logic [7:0] cpu_rdat;
	logic       mem_cyc;
	logic       mem_stb;
	logic       mem_we;
	phys_addr_t mem_adr;
	logic [7:0] mem_wdat;
	logic [7:0] mem_rdat;
	logic       mem_ack;
	ula_state_t ula;

	row_t  rows[$];
	string names[$];
	int    errors;

	zx_mapper_top #(
		.ROM_BASE (ROM_BASE),
		.RAM_BASE (RAM_BASE)
	) u_zx_mapper_top (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.model    (model),
		.cpu_cyc  (cpu_cyc),
		.cpu_stb  (cpu_stb),
		.cpu_req  (cpu_req),
		.cpu_ack  (cpu_ack),
		.cpu_rdat (cpu_rdat),
		.mem_cyc  (mem_cyc),
		.mem_stb  (mem_stb),
		.mem_we   (mem_we),
		.mem_adr  (mem_adr),
		.mem_wdat (mem_wdat),
		.mem_rdat (mem_rdat),
		.mem_ack  (mem_ack),
		.ula      (ula)
	);

	zx_mem_model u_mem (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cyc     (mem_cyc),
		.stb     (mem_stb),
		.we      (mem_we),
		.adr     (mem_adr),
		.wdat    (mem_wdat),
		.rdat    (mem_rdat),
		.ack     (mem_ack)
	);

	always #4 clk_sys = ~clk_sys;

	// ==================================================
	// Expected values
	// ==================================================
	function automatic phys_addr_t ram_adr(input int bank, input int off);
		return RAM_BASE + phys_addr_t'(bank * 16384 + off);
	endfunction

	function automatic phys_addr_t rom_adr(input int page, input int off);
		return ROM_BASE + phys_addr_t'(page * 16384 + off);
	endfunction

	// Pentagon bank is D5, D7, D6 above D2..D0
	function automatic int p1024_bank(input logic [7:0] d);
		return int'({d[5], d[7], d[6], d[2:0]});
	endfunction

	function automatic phys_addr_t ula_after_fe(input logic [7:0] d);
		ula_state_t u;
		u.border      = d[2:0];
		u.mic         = d[3];
		u.ear         = d[4];
		u.screen_page = 1'b0;
		return phys_addr_t'(u);
	endfunction

	task automatic add_row(input string name, input zx_model_t m, input logic [1:0] k,
			input cpu_addr_t a, input logic [7:0] d, input phys_addr_t e, input logic nm);
		row_t r;
		r.model   = m;
		r.kind    = k;
		r.adr     = a;
		r.dat     = d;
		r.exp_val = e;
		r.no_mem  = nm;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic fill_table();
		add_row("rst_ula_rd", MODEL_ZX128, K_IOR, 16'h00FE, 8'h00, 25'h0, 1'b1);
		add_row("128_c000_rd", MODEL_ZX128, K_RD, 16'hC123, 8'h00, ram_adr(0, 'h123), 1'b0);
		add_row("128_4000_rd", MODEL_ZX128, K_RD, 16'h4000, 8'h00, ram_adr(5, 0), 1'b0);
		add_row("128_8000_rd", MODEL_ZX128, K_RD, 16'h8010, 8'h00, ram_adr(2, 'h10), 1'b0);
		add_row("128_rom_rd", MODEL_ZX128, K_RD, 16'h0005, 8'h00, rom_adr(0, 5), 1'b0);
		// Screen page follows D3
		add_row("128_7ffd_b3", MODEL_ZX128, K_IOW, 16'h7FFD, 8'h1B, 25'h1, 1'b1);
		add_row("128_c000_b3", MODEL_ZX128, K_RD, 16'hC000, 8'h00, ram_adr(3, 0), 1'b0);
		add_row("128_rom1_rd", MODEL_ZX128, K_RD, 16'h0100, 8'h00, rom_adr(1, 'h100), 1'b0);
		add_row("128_7ffd_lock", MODEL_ZX128, K_IOW, 16'h7FFD, 8'h26, 25'h0, 1'b1);
		add_row("128_7ffd_locked", MODEL_ZX128, K_IOW, 16'h7FFD, 8'h01, 25'h0, 1'b1);
		add_row("128_c000_b6", MODEL_ZX128, K_RD, 16'hC000, 8'h00, ram_adr(6, 0), 1'b0);
		add_row("128_rom0_rd", MODEL_ZX128, K_RD, 16'h0000, 8'h00, rom_adr(0, 0), 1'b0);
		add_row("128_c004_wr", MODEL_ZX128, K_WR, 16'hC004, 8'hA5, ram_adr(6, 4), 1'b0);
		add_row("128_c004_rd", MODEL_ZX128, K_RD, 16'hC004, 8'h00, ram_adr(6, 4), 1'b0);
		add_row("48_7ffd", MODEL_ZX48, K_IOW, 16'h7FFD, 8'h1F, 25'h0, 1'b1);
		add_row("48_c000_rd", MODEL_ZX48, K_RD, 16'hC000, 8'h00, ram_adr(0, 0), 1'b0);
		add_row("48_rom_rd", MODEL_ZX48, K_RD, 16'h0000, 8'h00, rom_adr(3, 0), 1'b0);
		add_row("p1k_7ffd_e2", MODEL_P1024, K_IOW, 16'h7FFD, 8'hE2, 25'h0, 1'b1);
		add_row("p1k_c000_e2", MODEL_P1024, K_RD, 16'hC000, 8'h00,
				ram_adr(p1024_bank(8'hE2), 0), 1'b0);
		add_row("p1k_7ffd_41", MODEL_P1024, K_IOW, 16'h7FFD, 8'h41, 25'h0, 1'b1);
		add_row("p1k_c000_41", MODEL_P1024, K_RD, 16'hC000, 8'h00,
				ram_adr(p1024_bank(8'h41), 0), 1'b0);
		add_row("p1k_eff7", MODEL_P1024, K_IOW, 16'hEFF7, 8'h04, 25'h0, 1'b1);
		add_row("p1k_7ffd_e3", MODEL_P1024, K_IOW, 16'h7FFD, 8'hE3, 25'h0, 1'b1);
		// bank_hi stays 1 from the 41 write
		add_row("p1k_c000_e3", MODEL_P1024, K_RD, 16'hC000, 8'h00, ram_adr(8 + 3, 0), 1'b0);
		add_row("p3_rom_wr", MODEL_PLUS3, K_WR, 16'h0000, 8'h5C, rom_adr(0, 0), 1'b1);
		add_row("p3_1ffd_m0", MODEL_PLUS3, K_IOW, 16'h1FFD, 8'h01, 25'h0, 1'b1);
		add_row("p3_m0_0000", MODEL_PLUS3, K_RD, 16'h0000, 8'h00, ram_adr(0, 0), 1'b0);
		add_row("p3_m0_4000", MODEL_PLUS3, K_RD, 16'h4000, 8'h00, ram_adr(1, 0), 1'b0);
		add_row("p3_m0_c000", MODEL_PLUS3, K_RD, 16'hC000, 8'h00, ram_adr(3, 0), 1'b0);
		add_row("p3_m0_wr", MODEL_PLUS3, K_WR, 16'h0010, 8'h3C, ram_adr(0, 'h10), 1'b0);
		add_row("p3_m0_rd", MODEL_PLUS3, K_RD, 16'h0010, 8'h00, ram_adr(0, 'h10), 1'b0);
		add_row("p3_1ffd_m1", MODEL_PLUS3, K_IOW, 16'h1FFD, 8'h03, 25'h0, 1'b1);
		add_row("p3_m1_0000", MODEL_PLUS3, K_RD, 16'h0000, 8'h00, ram_adr(4, 0), 1'b0);
		add_row("p3_m1_c000", MODEL_PLUS3, K_RD, 16'hC000, 8'h00, ram_adr(7, 0), 1'b0);
		add_row("p3_1ffd_m2", MODEL_PLUS3, K_IOW, 16'h1FFD, 8'h05, 25'h0, 1'b1);
		add_row("p3_m2_4000", MODEL_PLUS3, K_RD, 16'h4000, 8'h00, ram_adr(5, 0), 1'b0);
		add_row("p3_m2_c000", MODEL_PLUS3, K_RD, 16'hC000, 8'h00, ram_adr(3, 0), 1'b0);
		add_row("p3_1ffd_m3", MODEL_PLUS3, K_IOW, 16'h1FFD, 8'h07, 25'h0, 1'b1);
		add_row("p3_m3_4000", MODEL_PLUS3, K_RD, 16'h4000, 8'h00, ram_adr(7, 0), 1'b0);
		add_row("p3_m3_8000", MODEL_PLUS3, K_RD, 16'h8000, 8'h00, ram_adr(6, 0), 1'b0);
		add_row("ula_fe_wr", MODEL_PLUS3, K_IOW, 16'h00FE, 8'h1D, ula_after_fe(8'h1D), 1'b1);
		add_row("ula_fe_rd", MODEL_PLUS3, K_IOR, 16'h00FE, 8'h00, ula_after_fe(8'h1D), 1'b1);
	endtask

	// ==================================================
	// Stimulus and checks
	// ==================================================
	task automatic report_mismatch(input string name, input string what,
			input logic [31:0] exp_v, input logic [31:0] act_v);
		$display("ERR %s %s: expected %h actual %h", name, what, exp_v, act_v);
		errors++;
	endtask

	task automatic apply_reset(input zx_model_t m);
		@(posedge clk_sys);
		#1;
		reset = 1'b1;
		model = m;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
	endtask

	task automatic check_response(input int i, input int n, input int cyc0, input int wr0);
		row_t r;
		r = rows[i];
		// I/O and dropped writes answer one cycle after the strobe
		if (r.no_mem && n != 1) begin
			report_mismatch(names[i], "ack latency", 1, n);
		end
		// Master cycle closes on the edge that raises cpu_ack
		if (mem_cyc || mem_stb) begin
			$display("%s: memory cycle still open at cpu_ack", names[i]);
			errors++;
		end
		if (r.no_mem) begin
			if (u_mem.n_cycles != cyc0) begin
				$display("%s: a memory cycle ran where none should", names[i]);
				errors++;
			end
		end else if (u_mem.n_cycles != cyc0 + 1) begin
			$display("%s: expected one memory cycle, saw %0d", names[i], u_mem.n_cycles - cyc0);
			errors++;
		end else if (u_mem.last_adr != r.exp_val) begin
			report_mismatch(names[i], "mem_adr", r.exp_val, u_mem.last_adr);
		end
		if (r.kind == K_IOW || r.kind == K_IOR) begin
			if (ula != r.exp_val[5:0]) begin
				report_mismatch(names[i], "ula", r.exp_val[5:0], ula);
			end
		end
		if (r.kind == K_IOR && cpu_rdat != 8'hFF) begin
			report_mismatch(names[i], "io rdat", 8'hFF, cpu_rdat);
		end
		if (r.kind == K_RD && cpu_rdat != u_mem.content(r.exp_val)) begin
			report_mismatch(names[i], "rdat", u_mem.content(r.exp_val), cpu_rdat);
		end
		if (r.kind == K_RD && u_mem.n_writes != wr0) begin
			$display("%s: a read reached memory as a write", names[i]);
			errors++;
		end
		if (r.kind == K_WR && !r.no_mem) begin
			if (u_mem.n_writes != wr0 + 1) begin
				$display("%s: the write did not reach memory", names[i]);
				errors++;
			end else if (u_mem.log_dat[wr0] != r.dat) begin
				report_mismatch(names[i], "wdat", r.dat, u_mem.log_dat[wr0]);
			end
		end
	endtask

	task automatic run_row(input int i);
		row_t r;
		int   n;
		int   cyc0;
		int   wr0;
		r    = rows[i];
		cyc0 = u_mem.n_cycles;
		wr0  = u_mem.n_writes;
		@(posedge clk_sys);
		#1;
		cpu_cyc     = 1'b1;
		cpu_stb     = 1'b1;
		cpu_req.io  = r.kind[1];
		cpu_req.we  = (r.kind == K_WR) || (r.kind == K_IOW);
		cpu_req.adr = r.adr;
		cpu_req.dat = r.dat;
		n = 0;
		do begin
			@(posedge clk_sys);
			#1;
			n++;
		end while (!cpu_ack && n < TIMEOUT);
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		if (!cpu_ack) begin
			$display("%s: no cpu_ack within %0d cycles", names[i], TIMEOUT);
			errors++;
		end else begin
			check_response(i, n, cyc0, wr0);
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		reset   = 1'b1;
		model   = MODEL_ZX128;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_req = '0;
		errors  = 0;
		fill_table();
		for (int i = 0; i < rows.size(); i++) begin
			// New model starts from a fresh reset
			if (i == 0 || rows[i].model != rows[i-1].model) begin
				apply_reset(rows[i].model);
			end
			run_row(i);
		end
		$display("%0d rows run, %0d errors", rows.size(), errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
design/zx_pkg.sv
design/zx_io_ports.sv
design/zx_mem_map.sv
design/zx_bus_bridge.sv
design/zx_mapper_top.sv
bench/zx_mem_model.sv
bench/zx_mapper_tb.sv

//--- Bender.yml
package:
  name: zx_mapper

sources:
  - design/zx_pkg.sv
  - design/zx_io_ports.sv
  - design/zx_mem_map.sv
  - design/zx_bus_bridge.sv
  - design/zx_mapper_top.sv
  - target: test
    files:
      - bench/zx_mem_model.sv
      - bench/zx_mapper_tb.sv
